// ==== filelist.f ====
hw/cpu_pkg.sv
hw/cpu_sram.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/cpu.sv
verification/tb_clock.sv
verification/cpu_asserts.sv
verification/cpu_tb.sv

// ==== hw/cpu.sv ====
// Five-stage pipelined MIPS32 subset core with external memory load/read ports
module cpu
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              enable,
   input  ext_port_t         imem_ext,
   input  ext_port_t         dmem_ext,
   output logic [data_w-1:0] dmem_ext_rdata
);

   if_id_t  if_id;
   id_ex_t  id_ex;
   ex_mem_t ex_mem;
   wb_t     wb;
   logic    data_stall;

   fetch_stage u_fetch (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .data_stall (data_stall),
      .imem_ext   (imem_ext),
      .if_id      (if_id)
   );

   decode_stage u_decode (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .if_id      (if_id),
      .wb         (wb),
      .id_ex      (id_ex),
      .data_stall (data_stall)
   );

   execute_stage u_execute (
      .clk    (clk),
      .reset  (reset),
      .enable (enable),
      .id_ex  (id_ex),
      .wb     (wb),
      .ex_mem (ex_mem)
   );

   result_stage u_result (
      .clk            (clk),
      .reset          (reset),
      .enable         (enable),
      .ex_mem         (ex_mem),
      .dmem_ext       (dmem_ext),
      .dmem_ext_rdata (dmem_ext_rdata),
      .wb             (wb)
   );

endmodule

// ==== hw/cpu_pkg.sv ====
// CPU shared definitions: widths, MIPS opcodes, ALU operations and pipeline register types
package cpu_pkg;

   localparam int data_w      = 32;
   localparam int reg_addr_w  = 5;
   localparam int imem_addr_w = 9;
   localparam int dmem_addr_w = 10;

   // primary opcodes
   localparam logic [5:0] op_rtype = 6'h00;
   localparam logic [5:0] op_addi  = 6'h08;
   localparam logic [5:0] op_lw    = 6'h23;
   localparam logic [5:0] op_sw    = 6'h2b;

   // function field of R-type
   localparam logic [5:0] fn_add = 6'h20;
   localparam logic [5:0] fn_sub = 6'h22;
   localparam logic [5:0] fn_and = 6'h24;
   localparam logic [5:0] fn_or  = 6'h25;
   localparam logic [5:0] fn_slt = 6'h2a;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_slt
   } alu_op_e;

   // external access to either memory, instruction memory uses the low address bits
   typedef struct packed {
      logic                   wen;
      logic                   ren;
      logic [dmem_addr_w-1:0] addr;
      logic [data_w-1:0]      wdata;
   } ext_port_t;

   typedef struct packed {
      logic              valid;
      logic [data_w-1:0] instr;
   } if_id_t;

   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    use_imm;
      alu_op_e alu_op;
   } ctrl_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      logic [reg_addr_w-1:0] rs;
      logic [reg_addr_w-1:0] rt;
      logic [reg_addr_w-1:0] dest;
      logic [data_w-1:0]     op_a;
      logic [data_w-1:0]     op_b;
      logic [data_w-1:0]     imm;
   } id_ex_t;

   typedef struct packed {
      logic                  reg_write;
      logic                  mem_read;
      logic                  mem_write;
      logic [reg_addr_w-1:0] dest;
      logic [data_w-1:0]     result;
      logic [data_w-1:0]     store_data;
   } ex_mem_t;

   typedef struct packed {
      logic                  wen;
      logic [reg_addr_w-1:0] dest;
      logic [data_w-1:0]     data;
   } wb_t;

endpackage

// ==== hw/cpu_sram.sv ====
// Word memory with registered reads on a core port and an external load/read port
module cpu_sram
   import cpu_pkg::*;
#(
   parameter int ADDR_W = 9
) (
   input  logic              clk,
   input  logic [ADDR_W-1:0] core_addr,
   input  logic              core_wen,
   input  logic [data_w-1:0] core_wdata,
   output logic [data_w-1:0] core_rdata,
   input  ext_port_t         ext,
   output logic [data_w-1:0] ext_rdata
);

   logic [data_w-1:0] mem [2**ADDR_W];
   logic [ADDR_W-1:0] ext_addr;

   assign ext_addr = ext.addr[ADDR_W-1:0];

   // external write has priority over the core
   always_ff @(posedge clk) begin
      if (ext.wen) begin
         mem[ext_addr] <= ext.wdata;
      end else if (core_wen) begin
         mem[core_addr] <= core_wdata;
      end
   end

   always_ff @(posedge clk) begin
      core_rdata <= mem[core_addr];
   end

   // external read data holds until the next read
   always_ff @(posedge clk) begin
      if (ext.ren) begin
         ext_rdata <= mem[ext_addr];
      end
   end

endmodule

// ==== hw/decode_stage.sv ====
// Decode stage: instruction decode, register file, load-use detection and the ID/EX register
module decode_stage
   import cpu_pkg::*;
(
   input  logic   clk,
   input  logic   reset,
   input  logic   enable,
   input  if_id_t if_id,
   input  wb_t    wb,
   output id_ex_t id_ex,
   output logic   data_stall
);

   logic [data_w-1:0]     regs [2**reg_addr_w];
   logic [5:0]            opcode;
   logic [5:0]            funct;
   logic [reg_addr_w-1:0] rs;
   logic [reg_addr_w-1:0] rt;
   logic [reg_addr_w-1:0] rd;
   logic [reg_addr_w-1:0] dest;
   ctrl_t                 ctrl;
   id_ex_t                id_next;

   assign opcode = if_id.instr[31:26];
   assign rs     = if_id.instr[25:21];
   assign rt     = if_id.instr[20:16];
   assign rd     = if_id.instr[15:11];
   assign funct  = if_id.instr[5:0];

   // unsupported opcodes and function codes leave every control low
   always_comb begin
      ctrl = '0;
      dest = '0;
      if (if_id.valid) begin
         case (opcode)
            op_rtype: begin
               dest           = rd;
               ctrl.reg_write = 1'b1;
               case (funct)
                  fn_add:  ctrl.alu_op = alu_add;
                  fn_sub:  ctrl.alu_op = alu_sub;
                  fn_and:  ctrl.alu_op = alu_and;
                  fn_or:   ctrl.alu_op = alu_or;
                  fn_slt:  ctrl.alu_op = alu_slt;
                  default: ctrl.reg_write = 1'b0;
               endcase
            end
            op_addi: begin
               dest           = rt;
               ctrl.reg_write = 1'b1;
               ctrl.use_imm   = 1'b1;
            end
            op_lw: begin
               dest           = rt;
               ctrl.reg_write = 1'b1;
               ctrl.mem_read  = 1'b1;
               ctrl.use_imm   = 1'b1;
            end
            op_sw: begin
               ctrl.mem_write = 1'b1;
               ctrl.use_imm   = 1'b1;
            end
            default: ctrl = '0;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (enable && wb.wen && wb.dest != '0) begin
         regs[wb.dest] <= wb.data;
      end
   end

   // r0 reads zero, a write in the same cycle reads back as the new value
   function automatic logic [data_w-1:0] read_reg(input logic [reg_addr_w-1:0] addr);
      logic [data_w-1:0] val;
      if (addr == '0) begin
         val = '0;
      end else if (wb.wen && wb.dest == addr) begin
         val = wb.data;
      end else begin
         val = regs[addr];
      end
      return val;
   endfunction

   // load in EX feeding the instruction in decode
   assign data_stall = if_id.valid && id_ex.ctrl.mem_read && id_ex.dest != '0 &&
                       (id_ex.dest == rs || id_ex.dest == rt);

   always_comb begin
      id_next.ctrl = ctrl;
      id_next.rs   = rs;
      id_next.rt   = rt;
      id_next.dest = dest;
      id_next.op_a = read_reg(rs);
      id_next.op_b = read_reg(rt);
      id_next.imm  = {{16{if_id.instr[15]}}, if_id.instr[15:0]};
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         id_ex <= '0;
      end else if (enable) begin
         if (data_stall) begin
            id_ex <= '0;
         end else begin
            id_ex <= id_next;
         end
      end
   end

endmodule

// ==== hw/execute_stage.sv ====
// Execute stage: operand forwarding, ALU and the EX/MEM register
module execute_stage
   import cpu_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    enable,
   input  id_ex_t  id_ex,
   input  wb_t     wb,
   output ex_mem_t ex_mem
);

   logic [data_w-1:0] rs_val;
   logic [data_w-1:0] rt_val;
   logic [data_w-1:0] alu_b;
   logic [data_w-1:0] alu_out;
   ex_mem_t           ex_next;

   // nearest producer wins: EX/MEM first, then MEM/WB
   function automatic logic [data_w-1:0] forward(
      input logic [reg_addr_w-1:0] src,
      input logic [data_w-1:0]     reg_val
   );
      logic [data_w-1:0] val;
      if (ex_mem.reg_write && ex_mem.dest != '0 && ex_mem.dest == src) begin
         val = ex_mem.result;
      end else if (wb.wen && wb.dest != '0 && wb.dest == src) begin
         val = wb.data;
      end else begin
         val = reg_val;
      end
      return val;
   endfunction

   assign rs_val = forward(id_ex.rs, id_ex.op_a);
   assign rt_val = forward(id_ex.rt, id_ex.op_b);
   assign alu_b  = id_ex.ctrl.use_imm ? id_ex.imm : rt_val;

   always_comb begin
      case (id_ex.ctrl.alu_op)
         alu_add: alu_out = rs_val + alu_b;
         alu_sub: alu_out = rs_val - alu_b;
         alu_and: alu_out = rs_val & alu_b;
         alu_or:  alu_out = rs_val | alu_b;
         // signed compare
         alu_slt: alu_out = ($signed(rs_val) < $signed(alu_b)) ? data_w'(1) : '0;
         default: alu_out = '0;
      endcase
   end

   always_comb begin
      ex_next.reg_write  = id_ex.ctrl.reg_write;
      ex_next.mem_read   = id_ex.ctrl.mem_read;
      ex_next.mem_write  = id_ex.ctrl.mem_write;
      ex_next.dest       = id_ex.dest;
      ex_next.result     = alu_out;
      ex_next.store_data = rt_val;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ex_mem <= '0;
      end else if (enable) begin
         ex_mem <= ex_next;
      end
   end

endmodule

// ==== hw/fetch_stage.sv ====
// Fetch stage: program counter, instruction memory and the IF/ID register
module fetch_stage
   import cpu_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      enable,
   input  logic      data_stall,
   input  ext_port_t imem_ext,
   output if_id_t    if_id
);

   logic [data_w-1:0] pc;
   logic [data_w-1:0] pc_next;
   logic [data_w-1:0] imem_rdata;
   logic              advance;

   assign advance = enable & ~data_stall;

   // memory is addressed with the next pc so its output always matches pc
   always_comb begin
      if (reset) begin
         pc_next = '0;
      end else if (advance) begin
         pc_next = pc + data_w'(4);
      end else begin
         pc_next = pc;
      end
   end

   always_ff @(posedge clk) begin
      pc <= pc_next;
   end

   cpu_sram #(
      .ADDR_W (imem_addr_w)
   ) u_imem (
      .clk        (clk),
      .core_addr  (pc_next[imem_addr_w+1:2]),
      .core_wen   (1'b0),
      .core_wdata ('0),
      .core_rdata (imem_rdata),
      .ext        (imem_ext),
      .ext_rdata  ()
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         if_id <= '0;
      end else if (advance) begin
         if_id.valid <= 1'b1;
         if_id.instr <= imem_rdata;
      end
   end

endmodule

// ==== hw/result_stage.sv ====
// Result stage: data memory access, the MEM/WB register and the writeback select
module result_stage
   import cpu_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              enable,
   input  ex_mem_t           ex_mem,
   input  ext_port_t         dmem_ext,
   output logic [data_w-1:0] dmem_ext_rdata,
   output wb_t               wb
);

   typedef struct packed {
      logic                  reg_write;
      logic                  mem_read;
      logic [reg_addr_w-1:0] dest;
      logic [data_w-1:0]     result;
   } mem_wb_t;

   mem_wb_t                mem_wb;
   logic [dmem_addr_w-1:0] dmem_addr;
   logic [data_w-1:0]      load_data;

   // while frozen the memory re-reads the address held in mem_wb so load data survives
   assign dmem_addr = enable ? ex_mem.result[dmem_addr_w+1:2]
                             : mem_wb.result[dmem_addr_w+1:2];

   cpu_sram #(
      .ADDR_W (dmem_addr_w)
   ) u_dmem (
      .clk        (clk),
      .core_addr  (dmem_addr),
      .core_wen   (enable & ex_mem.mem_write),
      .core_wdata (ex_mem.store_data),
      .core_rdata (load_data),
      .ext        (dmem_ext),
      .ext_rdata  (dmem_ext_rdata)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         mem_wb <= '0;
      end else if (enable) begin
         mem_wb.reg_write <= ex_mem.reg_write;
         mem_wb.mem_read  <= ex_mem.mem_read;
         mem_wb.dest      <= ex_mem.dest;
         mem_wb.result    <= ex_mem.result;
      end
   end

   assign wb.wen  = mem_wb.reg_write;
   assign wb.dest = mem_wb.dest;
   assign wb.data = mem_wb.mem_read ? load_data : mem_wb.result;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module cpu_tb -f filelist.f \
   || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vcpu_tb)
echo "$out"

grep -qx '>>> PASS' <<< "$out" && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== verification/cpu_asserts.sv ====
// Decode stage assertions: r0 reads, load-use stall bubble and reset of the ID/EX controls
module cpu_asserts
   import cpu_pkg::*;
(
   input logic                  clk,
   input logic                  reset,
   input logic                  enable,
   input logic [reg_addr_w-1:0] rs,
   input logic [reg_addr_w-1:0] rt,
   input logic [data_w-1:0]     op_a,
   input logic [data_w-1:0]     op_b,
   input logic                  data_stall,
   input ctrl_t                 ex_ctrl
);
   timeunit 1ns;
   timeprecision 1ps;

   // number of failed assertions
   int error_count = 0;

   r0_a_zero: assert property (@(posedge clk) disable iff (reset) (rs == '0) |-> (op_a == '0))
      else begin
         error_count++;
         $error("register 0 read as nonzero on operand a");
      end

   r0_b_zero: assert property (@(posedge clk) disable iff (reset) (rt == '0) |-> (op_b == '0))
      else begin
         error_count++;
         $error("register 0 read as nonzero on operand b");
      end

   // the bubble clears mem_read in EX, so the stall cannot repeat
   single_stall: assert property (@(posedge clk) disable iff (reset)
      (enable && data_stall) |=> !data_stall)
      else begin
         error_count++;
         $error("load-use stall lasted more than one cycle");
      end

   reset_ctrl: assert property (@(posedge clk) reset |=> (ex_ctrl == '0))
      else begin
         error_count++;
         $error("id_ex controls not cleared by reset");
      end

endmodule

bind decode_stage cpu_asserts u_asserts (
   .clk        (clk),
   .reset      (reset),
   .enable     (enable),
   .rs         (rs),
   .rt         (rt),
   .op_a       (id_next.op_a),
   .op_b       (id_next.op_b),
   .data_stall (data_stall),
   .ex_ctrl    (id_ex.ctrl)
);

// ==== verification/cpu_tb.sv ====
// CPU testbench: loads programs, runs the core and compares data memory with a reference model
module cpu_tb
   import cpu_pkg::*;
;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int max_prog    = 32;
   localparam int data_words  = 32;
   localparam int num_tests   = 5;
   localparam int test_cycles = (max_prog + 16) + data_words + 3 +
                                (max_prog + 20) + 2 * data_words;
   localparam int timeout_ns  = (num_tests * test_cycles * 2 + 50) * 8;

   logic              clk;
   logic              reset;
   logic              reset_req;
   logic              enable;
   ext_port_t         imem_ext;
   ext_port_t         dmem_ext;
   logic [data_w-1:0] dmem_ext_rdata;

   logic [31:0] prog [$];
   logic [31:0] dinit [data_words];
   logic [31:0] ref_mem [1024];
   string       test_name;
   int          test_errs;
   int          total_errs;
   int          failed;
   int          checks;
   int          rd_addr;
   logic [31:0] rd_data;
   event        word_read;

   tb_clock u_clock (.reset_req(reset_req), .clk(clk), .reset(reset));

   cpu u_dut (
      .clk            (clk),
      .reset          (reset),
      .enable         (enable),
      .imem_ext       (imem_ext),
      .dmem_ext       (dmem_ext),
      .dmem_ext_rdata (dmem_ext_rdata)
   );

   function automatic logic [31:0] rtype_word(logic [5:0] fn, int rd, int rs, int rt);
      return {op_rtype, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
   endfunction

   function automatic logic [31:0] itype_word(logic [5:0] op, int rt, int rs, logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   // ISA-level interpreter, one instruction at a time in program order
   function automatic void ref_run();
      logic [31:0] regs [32];
      logic [31:0] ins;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] res;
      logic        wr;
      int          dst;
      foreach (regs[r]) regs[r] = '0;
      foreach (ref_mem[m]) ref_mem[m] = (m < data_words) ? dinit[m] : '0;
      foreach (prog[i]) begin
         ins = prog[i];
         a   = regs[ins[25:21]];
         b   = regs[ins[20:16]];
         imm = {{16{ins[15]}}, ins[15:0]};
         wr  = 1'b0;
         dst = ins[20:16];
         res = '0;
         case (ins[31:26])
            op_rtype: begin
               dst = ins[15:11];
               wr  = 1'b1;
               case (ins[5:0])
                  fn_add:  res = a + b;
                  fn_sub:  res = a - b;
                  fn_and:  res = a & b;
                  fn_or:   res = a | b;
                  fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: wr = 1'b0;
               endcase
            end
            op_addi: begin
               wr  = 1'b1;
               res = a + imm;
            end
            op_lw: begin
               wr  = 1'b1;
               res = ref_mem[((a + imm) >> 2) & 1023];
            end
            op_sw: ref_mem[((a + imm) >> 2) & 1023] = b;
            default: wr = 1'b0;
         endcase
         if (wr && dst != 0) regs[dst] = res;
      end
   endfunction

   task automatic load_memories();
      for (int i = 0; i < max_prog + 16; i++) begin
         @(negedge clk);
         imem_ext = {1'b1, 1'b0, dmem_addr_w'(i), (i < prog.size()) ? prog[i] : 32'd0};
      end
      for (int i = 0; i < data_words; i++) begin
         dinit[i] = $urandom();
         @(negedge clk);
         imem_ext = '0;
         dmem_ext = {1'b1, 1'b0, dmem_addr_w'(i), dinit[i]};
      end
      @(negedge clk);
      dmem_ext = '0;
   endtask

   task automatic run_core(int len, bit freeze);
      @(negedge clk);
      reset_req = 1'b1;
      repeat (2) @(negedge clk);
      reset_req = 1'b0;
      enable    = 1'b1;
      if (freeze) begin
         repeat (len / 2) @(negedge clk);
         enable = 1'b0;
         repeat (6) @(negedge clk);
         enable = 1'b1;
         repeat (len + 10 - len / 2) @(negedge clk);
      end else begin
         repeat (len + 10) @(negedge clk);
      end
      enable = 1'b0;
   endtask

   task automatic read_back();
      for (int i = 0; i < data_words; i++) begin
         dmem_ext = {1'b0, 1'b1, dmem_addr_w'(i), 32'd0};
         @(negedge clk);
         dmem_ext = '0;
         rd_addr  = i;
         rd_data  = dmem_ext_rdata;
         -> word_read;
         @(negedge clk);
      end
   endtask

   always @(word_read) begin
      checks++;
      if (rd_data !== ref_mem[rd_addr]) begin
         $display("mismatch %s word %0d expected %08h actual %08h",
                  test_name, rd_addr, ref_mem[rd_addr], rd_data);
         test_errs++;
      end
   end

   task automatic run_test(string name, bit freeze);
      test_name = name;
      test_errs = 0;
      load_memories();
      ref_run();
      run_core(prog.size(), freeze);
      read_back();
      $display("%s: %0d errors", name, test_errs);
      total_errs += test_errs;
      if (test_errs != 0) failed++;
   endtask

   // mixed program reused by the freeze test
   task automatic build_mixed();
      prog.delete();
      prog.push_back(itype_word(op_lw, 1, 0, 16'd8));
      prog.push_back(itype_word(op_addi, 2, 1, 16'($urandom())));
      prog.push_back(rtype_word(fn_sub, 3, 2, 1));
      prog.push_back(itype_word(op_sw, 3, 0, 16'd64));
      prog.push_back(itype_word(op_lw, 4, 0, 16'd12));
      prog.push_back(rtype_word(fn_or, 5, 4, 3));
      prog.push_back(rtype_word(fn_slt, 6, 3, 5));
      prog.push_back(itype_word(op_sw, 5, 0, 16'd68));
      prog.push_back(itype_word(op_sw, 6, 0, 16'd72));
   endtask

   initial begin
      void'($urandom(5959));
      enable     = 1'b0;
      reset_req  = 1'b0;
      imem_ext   = '0;
      dmem_ext   = '0;
      total_errs = 0;
      failed     = 0;
      checks     = 0;
      wait (!reset);

      prog.delete();
      for (int r = 1; r <= 2; r++) prog.push_back(itype_word(op_addi, r, 0, 16'($urandom())));
      prog.push_back(itype_word(op_addi, 3, 0, 16'hfffb));
      prog.push_back(rtype_word(fn_add, 4, 1, 2));
      prog.push_back(rtype_word(fn_sub, 5, 1, 2));
      prog.push_back(rtype_word(fn_and, 6, 1, 2));
      prog.push_back(rtype_word(fn_or, 7, 1, 2));
      prog.push_back(rtype_word(fn_slt, 8, 3, 1));
      prog.push_back(rtype_word(fn_slt, 9, 1, 3));
      for (int r = 4; r <= 9; r++) prog.push_back(itype_word(op_sw, r, 0, 16'(64 + 4 * (r - 4))));
      run_test("arith", 1'b0);

      prog.delete();
      prog.push_back(itype_word(op_addi, 1, 0, 16'($urandom())));
      prog.push_back(itype_word(op_addi, 2, 1, 16'($urandom())));
      prog.push_back(rtype_word(fn_add, 3, 2, 1));
      prog.push_back(rtype_word(fn_sub, 4, 3, 2));
      prog.push_back(rtype_word(fn_or, 5, 4, 3));
      prog.push_back(itype_word(op_sw, 5, 0, 16'd64));
      prog.push_back(rtype_word(fn_add, 6, 5, 4));
      prog.push_back(itype_word(op_sw, 6, 0, 16'd68));
      prog.push_back(rtype_word(fn_and, 7, 6, 5));
      prog.push_back(itype_word(op_sw, 7, 0, 16'd72));
      run_test("forwarding", 1'b0);

      prog.delete();
      prog.push_back(itype_word(op_lw, 1, 0, 16'd0));
      prog.push_back(rtype_word(fn_add, 2, 1, 1));
      prog.push_back(itype_word(op_sw, 2, 0, 16'd64));
      prog.push_back(itype_word(op_lw, 3, 0, 16'd4));
      prog.push_back(itype_word(op_sw, 3, 0, 16'd68));
      prog.push_back(itype_word(op_addi, 4, 0, 16'd8));
      prog.push_back(itype_word(op_lw, 5, 4, 16'd4));
      prog.push_back(itype_word(op_addi, 6, 5, 16'd1));
      prog.push_back(itype_word(op_sw, 6, 0, 16'd72));
      run_test("load_use", 1'b0);

      prog.delete();
      prog.push_back(itype_word(op_addi, 1, 0, 16'd7));
      prog.push_back(itype_word(op_addi, 0, 0, 16'd123));
      prog.push_back(rtype_word(fn_add, 0, 1, 1));
      prog.push_back(itype_word(op_addi, 2, 0, 16'd55));
      prog.push_back(itype_word(op_sw, 2, 0, 16'd64));
      prog.push_back(itype_word(op_lw, 0, 0, 16'd0));
      prog.push_back(itype_word(op_addi, 3, 0, 16'd99));
      prog.push_back(itype_word(op_sw, 3, 0, 16'd68));
      prog.push_back(itype_word(op_sw, 0, 0, 16'd72));
      run_test("reg_zero", 1'b0);

      build_mixed();
      run_test("freeze", 1'b1);

      $display("tests %0d, failed %0d, words %0d, mismatches %0d, assertion failures %0d",
               num_tests, failed, checks, total_errs, u_dut.u_decode.u_asserts.error_count);
      if (failed == 0 && u_dut.u_decode.u_asserts.error_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin
      #(timeout_ns * 1ns);
      $display("error: simulation timed out after %0d ns", timeout_ns);
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== verification/tb_clock.sv ====
// Testbench clock and reset generator: 8 ns clock, reset held for the first 5 cycles
module tb_clock (
   input  logic reset_req,
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 1ps;

   logic por;

   initial begin
      clk = 1'b0;
      por = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      por = 1'b0;
   end

   always #4 clk = ~clk;

   assign reset = por | reset_req;

endmodule
